// File: Makefile
# Verilator build and run of the board control testbench

VERILATOR ?= verilator
TOP       ?= tb_frame_board
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build and run the testbench, fails unless it reports a pass"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)

// File: frame_board.sv
// ======================================================================
// Board control top: status decoder, reset sequencer, joystick mapper
// ======================================================================
`timescale 1ns/100ps

module frame_board (
    input  logic                        clk_sys,
    input  logic                        reset,
    input  logic                        pll_locked,
    input  logic                        rst_req,
    input  logic                        downloading,
    input  logic [31:0]                 status,
    input  frame_input_pkg::board_joy_t joystick1,
    input  frame_input_pkg::board_joy_t joystick2,
    output logic                        rst,
    output logic                        game_rst,
    output frame_ctrl_pkg::dip_cfg_t    dip,
    output logic                        dip_pause,
    output frame_input_pkg::game_joy_t  game_joystick1,
    output frame_input_pkg::game_joy_t  game_joystick2,
    output frame_input_pkg::game_ctrl_t game_ctrl
);

    frame_dip_decode u_decode (
        .clk_sys ( clk_sys ),
        .reset   ( reset   ),
        .status  ( status  ),
        .dip     ( dip     )
    );

    // A flip change restarts the game
    frame_rst_seq u_rst (
        .clk_sys     ( clk_sys     ),
        .reset       ( reset       ),
        .pll_locked  ( pll_locked  ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .flip        ( dip.flip    ),
        .rst         ( rst         ),
        .game_rst    ( game_rst    )
    );

    frame_joy_map u_map (
        .clk_sys        ( clk_sys        ),
        .reset          ( reset          ),
        .game_rst       ( game_rst       ),
        .dip_pause_sw   ( dip.pause      ),
        .joystick1      ( joystick1      ),
        .joystick2      ( joystick2      ),
        .game_joystick1 ( game_joystick1 ),
        .game_joystick2 ( game_joystick2 ),
        .game_ctrl      ( game_ctrl      ),
        .dip_pause      ( dip_pause      )
    );

endmodule

// File: frame_board_sva.sv
// ======================================================================
// Concurrent checks on the reset sequence and game reset blanking,
// bound into the board control top
// ======================================================================
`timescale 1ns/100ps
`include "frame_settings.svh"

module frame_board_sva (
    input logic                        clk_sys,
    input logic                        reset,
    input logic                        rst,
    input logic                        game_rst,
    input logic                        rst_req,
    input frame_input_pkg::game_joy_t  game_joystick1,
    input frame_input_pkg::game_joy_t  game_joystick2,
    input frame_input_pkg::game_ctrl_t game_ctrl
);

    localparam logic [9:0] IDLE_JOY  = {10{1'(`FRAME_ACTIVE_LOW)}};
    localparam logic [4:0] IDLE_CTRL = {5{1'(`FRAME_ACTIVE_LOW)}};

    // Number of failed assertions so far
    int fail_count = 0;

    // Board reset always covers the game
    rst_covers_game: assert property (@(posedge clk_sys) disable iff (reset)
        rst |-> game_rst)
        else begin
            fail_count = fail_count + 1;
            $error("rst high while game_rst is low");
        end

    // Game sees released controls while held in reset
    game_rst_blanks: assert property (@(posedge clk_sys) disable iff (reset)
        game_rst |=> (game_joystick1 == IDLE_JOY) && (game_joystick2 == IDLE_JOY) &&
                     (game_ctrl == IDLE_CTRL))
        else begin
            fail_count = fail_count + 1;
            $error("game outputs active one cycle after game_rst");
        end

    // Reset request while running
    req_restarts_game: assert property (@(posedge clk_sys) disable iff (reset)
        (rst_req && !game_rst) |=> game_rst)
        else begin
            fail_count = fail_count + 1;
            $error("rst_req while running did not raise game_rst");
        end

endmodule

bind frame_board frame_board_sva sva0 (
    .clk_sys        ( clk_sys        ),
    .reset          ( reset          ),
    .rst            ( rst            ),
    .game_rst       ( game_rst       ),
    .rst_req        ( rst_req        ),
    .game_joystick1 ( game_joystick1 ),
    .game_joystick2 ( game_joystick2 ),
    .game_ctrl      ( game_ctrl      )
);

// File: frame_ctrl_pkg.sv
// ======================================================================
// Control types: decoded DIP/OSD settings and reset sequencer states
// ======================================================================

package frame_ctrl_pkg;

    // Settings decoded from the microcontroller status word
    typedef struct packed {
        logic        flip;
        logic        test;
        logic        pause;
        logic [1:0]  fxlevel;
        logic        enable_fm;
        logic        enable_psg;
        // Game specific DIP switches
        logic [15:0] game_dip;
        logic        spare;
    } dip_cfg_t;

    // Reset sequencer states
    typedef enum logic [1:0] {
        // Held until the PLL reports lock
        RST_WAIT_PLL,
        // Board reset countdown
        RST_BOARD,
        // Game only reset countdown
        RST_GAME,
        // Normal operation
        RST_RUN
    } rst_state_e;

endpackage

// File: frame_dip_decode.sv
// ======================================================================
// Status word decoder: registers OSD and DIP fields into the settings
// struct, turning the sound disable bits into enables
// ======================================================================
`timescale 1ns/100ps
`include "frame_settings.svh"

module frame_dip_decode (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  logic [31:0]              status,
    output frame_ctrl_pkg::dip_cfg_t dip
);

    // Both sound chips stay on after reset
    localparam frame_ctrl_pkg::dip_cfg_t DIP_RESET = '{
        enable_fm:  1'b1,
        enable_psg: 1'b1,
        default:    '0
    };

    frame_ctrl_pkg::dip_cfg_t dip_nxt;

    always_comb begin
        dip_nxt            = '0;
        dip_nxt.flip       = status[1];
        dip_nxt.test       = status[2];
        dip_nxt.pause      = status[3];
        dip_nxt.fxlevel    = status[5:4];
        // OSD stores disables
        dip_nxt.enable_fm  = ~status[6];
        dip_nxt.enable_psg = ~status[7];
        dip_nxt.game_dip   = status[`FRAME_DIPBASE +: 16];
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            dip <= DIP_RESET;
        end else begin
            dip <= dip_nxt;
        end
    end

endmodule

// File: frame_input_pkg.sv
// ======================================================================
// Input types: board joystick word, game joystick and game controls
// ======================================================================

package frame_input_pkg;

    // Joystick word from the board, always active high
    typedef struct packed {
        logic [1:0] spare;
        logic       pause;
        logic       service;
        logic       coin;
        logic       start;
        logic [5:0] buttons;
        // Right, left, down, up from bit 0
        logic [3:0] dir;
    } board_joy_t;

    // Joystick as seen by the game, polarity applied
    typedef struct packed {
        logic [5:0] buttons;
        logic [3:0] dir;
    } game_joy_t;

    // Cabinet controls, bit 0 is player 1
    typedef struct packed {
        logic [1:0] coin;
        logic [1:0] start;
        logic       service;
    } game_ctrl_t;

endpackage

// File: frame_joy_map.sv
// ======================================================================
// Joystick mapper: button masking, coin/start/service routing,
// output polarity, game reset blanking and the joystick pause toggle
// ======================================================================
`timescale 1ns/100ps
`include "frame_settings.svh"

module frame_joy_map (
    input  logic                        clk_sys,
    input  logic                        reset,
    input  logic                        game_rst,
    input  logic                        dip_pause_sw,
    input  frame_input_pkg::board_joy_t joystick1,
    input  frame_input_pkg::board_joy_t joystick2,
    output frame_input_pkg::game_joy_t  game_joystick1,
    output frame_input_pkg::game_joy_t  game_joystick2,
    output frame_input_pkg::game_ctrl_t game_ctrl,
    output logic                        dip_pause
);

    localparam int         BUTTONS    = `FRAME_BUTTONS;
    localparam logic [5:0] BTN_MASK   = 6'((1 << BUTTONS) - 1);
    localparam logic       ACTIVE_LOW = 1'(`FRAME_ACTIVE_LOW);
    // XOR patterns that turn active high values into game polarity
    localparam logic [9:0] JOY_POL    = {10{ACTIVE_LOW}};
    localparam logic [4:0] CTRL_POL   = {5{ACTIVE_LOW}};

    frame_input_pkg::game_joy_t  joy1_hi;
    frame_input_pkg::game_joy_t  joy2_hi;
    frame_input_pkg::game_ctrl_t ctrl_hi;
    logic                        pause_last;
    logic                        pause_tgl;
    logic                        pause_rise;

    // Drops buttons the game does not have
    function automatic frame_input_pkg::game_joy_t map_joy(
        input frame_input_pkg::board_joy_t joy
    );
        frame_input_pkg::game_joy_t g;
        g.buttons = joy.buttons & BTN_MASK;
        g.dir     = joy.dir;
        return g;
    endfunction

    // Active high view, all released while the game is in reset
    always_comb begin
        joy1_hi         = map_joy(joystick1);
        joy2_hi         = map_joy(joystick2);
        ctrl_hi.coin    = {joystick2.coin, joystick1.coin};
        ctrl_hi.start   = {joystick2.start, joystick1.start};
        // Service switch only on player 1
        ctrl_hi.service = joystick1.service;
        if (game_rst) begin
            joy1_hi = '0;
            joy2_hi = '0;
            ctrl_hi = '0;
        end
    end

    assign pause_rise = joystick1.pause & ~pause_last;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            game_joystick1 <= JOY_POL;
            game_joystick2 <= JOY_POL;
            game_ctrl      <= CTRL_POL;
            pause_last     <= 1'b0;
            pause_tgl      <= 1'b0;
        end else begin
            game_joystick1 <= joy1_hi ^ JOY_POL;
            game_joystick2 <= joy2_hi ^ JOY_POL;
            game_ctrl      <= ctrl_hi ^ CTRL_POL;
            pause_last     <= joystick1.pause;
            if (pause_rise) begin
                pause_tgl <= ~pause_tgl;
            end
        end
    end

    // Joystick press flips whatever the OSD pause setting says
    assign dip_pause = dip_pause_sw ^ pause_tgl;

endmodule

// File: frame_rst_seq.sv
// ======================================================================
// Reset sequencer: board reset after PLL lock, then game reset,
// re-entered on reset requests, flip changes and downloads
// ======================================================================
`timescale 1ns/100ps
`include "frame_settings.svh"

module frame_rst_seq (
    input  logic clk_sys,
    input  logic reset,
    input  logic pll_locked,
    input  logic rst_req,
    input  logic downloading,
    input  logic flip,
    output logic rst,
    output logic game_rst
);

    localparam int RST_LEN  = `FRAME_RST_CYCLES;
    localparam int GAME_LEN = `FRAME_GAME_RST_CYCLES;
    localparam int CNT_MAX  = (RST_LEN > GAME_LEN) ? RST_LEN : GAME_LEN;
    localparam int CW       = $clog2(CNT_MAX + 1);

    frame_ctrl_pkg::rst_state_e state;
    frame_ctrl_pkg::rst_state_e state_nxt;
    logic [CW-1:0]              cnt;
    logic [CW-1:0]              cnt_nxt;
    logic                       flip_last;
    logic                       game_req;

    // Anything that restarts the game without touching the board
    assign game_req = rst_req | (flip != flip_last) | downloading;

    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;
        unique case (state)
            frame_ctrl_pkg::RST_WAIT_PLL: begin
                if (pll_locked) begin
                    state_nxt = frame_ctrl_pkg::RST_BOARD;
                    cnt_nxt   = CW'(RST_LEN - 1);
                end
            end
            frame_ctrl_pkg::RST_BOARD: begin
                if (cnt == '0) begin
                    state_nxt = frame_ctrl_pkg::RST_GAME;
                    cnt_nxt   = CW'(GAME_LEN - 1);
                end else begin
                    cnt_nxt = cnt - 1'b1;
                end
            end
            frame_ctrl_pkg::RST_GAME: begin
                // Count restarts while a request or download is active
                if (game_req) begin
                    cnt_nxt = CW'(GAME_LEN - 1);
                end else if (cnt == '0) begin
                    state_nxt = frame_ctrl_pkg::RST_RUN;
                end else begin
                    cnt_nxt = cnt - 1'b1;
                end
            end
            frame_ctrl_pkg::RST_RUN: begin
                if (game_req) begin
                    state_nxt = frame_ctrl_pkg::RST_GAME;
                    cnt_nxt   = CW'(GAME_LEN - 1);
                end
            end
        endcase
        // Losing lock restarts everything
        if (!pll_locked) begin
            state_nxt = frame_ctrl_pkg::RST_WAIT_PLL;
        end
    end

    // Outputs registered from the next state, same timing as a state decode
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state     <= frame_ctrl_pkg::RST_WAIT_PLL;
            cnt       <= '0;
            flip_last <= 1'b0;
            rst       <= 1'b1;
            game_rst  <= 1'b1;
        end else begin
            state     <= state_nxt;
            cnt       <= cnt_nxt;
            flip_last <= flip;
            rst       <= (state_nxt == frame_ctrl_pkg::RST_WAIT_PLL) ||
                         (state_nxt == frame_ctrl_pkg::RST_BOARD);
            game_rst  <= (state_nxt != frame_ctrl_pkg::RST_RUN);
        end
    end

endmodule

// File: frame_settings.svh
// ======================================================================
// Build-time settings of the board control block: fire button count,
// game input polarity, DIP field offset and reset sequence lengths
// ======================================================================
`ifndef FRAME_SETTINGS_SVH
`define FRAME_SETTINGS_SVH

// Live fire buttons, 1 to 6
`define FRAME_BUTTONS 2

// Game inputs are active low when set
`define FRAME_ACTIVE_LOW 1

// First status bit of the 16-bit game DIP field
`define FRAME_DIPBASE 16

// Board reset length once the PLL is locked
`define FRAME_RST_CYCLES 8

// Game reset length after a request, counted with no download active
`define FRAME_GAME_RST_CYCLES 4

`endif

// File: tb_frame_board.sv
// ======================================================================
// Testbench of the board control top: reset sequence timing, status
// table with directed and random joystick rows, game reset causes
// ======================================================================
`timescale 1ns/100ps
`include "frame_settings.svh"

module tb_frame_board;

    localparam int NUM_DIRECTED = 8;
    localparam int NUM_ROWS     = NUM_DIRECTED + 12;
    localparam int TIMEOUT      = 100;
    localparam logic [9:0] IDLE_JOY  = {10{1'(`FRAME_ACTIVE_LOW)}};
    localparam logic [4:0] IDLE_CTRL = {5{1'(`FRAME_ACTIVE_LOW)}};

    typedef struct packed {
        logic [31:0]                 status;
        frame_input_pkg::board_joy_t joy1;
        frame_input_pkg::board_joy_t joy2;
        logic                        press;
        frame_ctrl_pkg::dip_cfg_t    exp_dip;
        logic                        exp_pause;
        frame_input_pkg::game_joy_t  exp_joy1;
        frame_input_pkg::game_joy_t  exp_joy2;
        frame_input_pkg::game_ctrl_t exp_ctrl;
    } row_t;

    logic clk_sys, reset, pll_locked, rst_req, downloading;
    logic [31:0] status;
    frame_input_pkg::board_joy_t joystick1, joystick2;
    logic rst, game_rst, dip_pause;
    frame_ctrl_pkg::dip_cfg_t dip;
    frame_input_pkg::game_joy_t game_joystick1, game_joystick2;
    frame_input_pkg::game_ctrl_t game_ctrl;
    row_t rows [NUM_ROWS];
    logic model_press, model_tgl;

    frame_board dut0 (
        .clk_sys(clk_sys), .reset(reset), .pll_locked(pll_locked), .rst_req(rst_req),
        .downloading(downloading), .status(status), .joystick1(joystick1),
        .joystick2(joystick2), .rst(rst), .game_rst(game_rst), .dip(dip),
        .dip_pause(dip_pause), .game_joystick1(game_joystick1),
        .game_joystick2(game_joystick2), .game_ctrl(game_ctrl)
    );

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Status bit map, sound bits are disables
    function automatic frame_ctrl_pkg::dip_cfg_t expect_dip(input logic [31:0] s);
        frame_ctrl_pkg::dip_cfg_t d;
        d = '0;
        d.flip       = s[1];
        d.test       = s[2];
        d.pause      = s[3];
        d.fxlevel    = s[5:4];
        d.enable_fm  = !s[6];
        d.enable_psg = !s[7];
        d.game_dip   = s[`FRAME_DIPBASE +: 16];
        return d;
    endfunction

    function automatic frame_input_pkg::game_joy_t expect_joy(
        input frame_input_pkg::board_joy_t j
    );
        frame_input_pkg::game_joy_t g;
        g.dir = j.dir;
        for (int i = 0; i < 6; i++) begin
            g.buttons[i] = (i < `FRAME_BUTTONS) ? j.buttons[i] : 1'b0;
        end
        return frame_input_pkg::game_joy_t'(g ^ IDLE_JOY);
    endfunction

    function automatic frame_input_pkg::game_ctrl_t expect_ctrl(
        input frame_input_pkg::board_joy_t j1,
        input frame_input_pkg::board_joy_t j2
    );
        frame_input_pkg::game_ctrl_t c;
        c.coin    = {j2.coin, j1.coin};
        c.start   = {j2.start, j1.start};
        c.service = j1.service;
        return frame_input_pkg::game_ctrl_t'(c ^ IDLE_CTRL);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_dip(input string name, input frame_ctrl_pkg::dip_cfg_t got,
                             input frame_ctrl_pkg::dip_cfg_t exp);
        if (got !== exp) fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_joy(input string name, input frame_input_pkg::game_joy_t got,
                             input frame_input_pkg::game_joy_t exp);
        if (got !== exp) fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_ctrl(input string name, input frame_input_pkg::game_ctrl_t got,
                              input frame_input_pkg::game_ctrl_t exp);
        if (got !== exp) fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) fail_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    endtask

    task automatic add_row(input int idx, input logic [31:0] st, input logic [15:0] j1,
                           input logic [15:0] j2, input logic press);
        row_t row;
        row.status     = st;
        row.joy1       = frame_input_pkg::board_joy_t'(j1);
        row.joy2       = frame_input_pkg::board_joy_t'(j2);
        row.press      = press;
        // Only a rising press flips the pause toggle
        if (press && !model_press) model_tgl = !model_tgl;
        model_press   = press;
        row.exp_dip   = expect_dip(st);
        row.exp_pause = st[3] ^ model_tgl;
        row.exp_joy1  = expect_joy(row.joy1);
        row.exp_joy2  = expect_joy(row.joy2);
        row.exp_ctrl  = expect_ctrl(row.joy1, row.joy2);
        rows[idx]     = row;
    endtask

    // Flip stays clear in every row so the game keeps running
    task automatic build_table();
        logic [31:0] seed, st;
        seed        = 32'h7de436a1;
        model_press = 1'b0;
        model_tgl   = 1'b0;
        add_row(0, 32'h0000_0000, 16'h0000, 16'h0000, 1'b0);
        add_row(1, 32'h0000_0004, 16'h0001, 16'h0008, 1'b1);
        add_row(2, 32'h0000_0038, 16'h03f0, 16'h0000, 1'b1);
        add_row(3, 32'h0000_00c0, 16'h0000, 16'h0c00, 1'b0);
        add_row(4, 32'ha5c3_0000, 16'h1c06, 16'h0000, 1'b1);
        add_row(5, 32'h5a3c_00f8, 16'h0000, 16'h03ff, 1'b0);
        add_row(6, 32'hffff_fffd, 16'hffff, 16'hffff, 1'b1);
        add_row(7, 32'h1234_0010, 16'h0015, 16'h002a, 1'b0);
        for (int i = NUM_DIRECTED; i < NUM_ROWS; i++) begin
            seed = lcg_next(seed);
            st   = seed & ~32'h2;
            seed = lcg_next(seed);
            add_row(i, st, seed[31:16], seed[15:0], lcg_next(seed) >= 32'h8000_0000);
        end
    endtask

    task automatic wait_game_rst(input logic level);
        for (int n = 0; n < TIMEOUT; n++) begin
            @(negedge clk_sys);
            if (game_rst === level) return;
        end
        fail_run($sformatf("game_rst did not go to %0b within %0d cycles", level, TIMEOUT));
    endtask

    // Counted from the cycle in which pll_locked is driven high
    task automatic measure_board_reset();
        int n;
        n = 0;
        while (rst === 1'b1 && n <= TIMEOUT) begin
            @(posedge clk_sys);
            @(negedge clk_sys);
            n++;
        end
        if (rst === 1'b1) fail_run("rst stayed high after pll_locked rose");
        if (n != `FRAME_RST_CYCLES + 1) begin
            fail_run($sformatf("[ERROR] rst cycles got %h expected %h", n,
                               `FRAME_RST_CYCLES + 1));
        end
    endtask

    task automatic expect_blanked();
        wait_game_rst(1'b1);
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_joy("game_joystick1", game_joystick1, IDLE_JOY);
        check_joy("game_joystick2", game_joystick2, IDLE_JOY);
        check_ctrl("game_ctrl", game_ctrl, IDLE_CTRL);
    endtask

    task automatic expect_recovered();
        wait_game_rst(1'b0);
        @(posedge clk_sys);
        @(negedge clk_sys);
        check_joy("game_joystick1", game_joystick1, expect_joy(joystick1));
        check_joy("game_joystick2", game_joystick2, expect_joy(joystick2));
        check_ctrl("game_ctrl", game_ctrl, expect_ctrl(joystick1, joystick2));
    endtask

    task automatic run_table();
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk_sys);
            #2;
            status          = rows[r].status;
            joystick1       = rows[r].joy1;
            joystick1.pause = rows[r].press;
            joystick2       = rows[r].joy2;
            @(posedge clk_sys);
            @(negedge clk_sys);
            check_dip("dip", dip, rows[r].exp_dip);
            check_bit("dip_pause", dip_pause, rows[r].exp_pause);
            check_joy("game_joystick1", game_joystick1, rows[r].exp_joy1);
            check_joy("game_joystick2", game_joystick2, rows[r].exp_joy2);
            check_ctrl("game_ctrl", game_ctrl, rows[r].exp_ctrl);
            check_bit("game_rst", game_rst, 1'b0);
        end
    endtask

    task automatic drive_status(input logic [31:0] st);
        @(posedge clk_sys);
        #2;
        status = st;
    endtask

    initial begin
        reset       = 1'b1;
        pll_locked  = 1'b0;
        rst_req     = 1'b0;
        downloading = 1'b0;
        status      = '0;
        joystick1   = '0;
        joystick2   = '0;
        build_table();
        repeat (2) @(posedge clk_sys);
        #2;
        reset = 1'b0;
        // Board held in reset until the PLL locks
        repeat (3) @(posedge clk_sys);
        #2;
        check_bit("rst", rst, 1'b1);
        check_bit("game_rst", game_rst, 1'b1);
        pll_locked = 1'b1;
        measure_board_reset();
        wait_game_rst(1'b0);
        run_table();
        @(posedge clk_sys);
        #2;
        rst_req = 1'b1;
        @(posedge clk_sys);
        #2;
        rst_req = 1'b0;
        expect_blanked();
        expect_recovered();
        // Flip change in both directions
        drive_status(status | 32'h2);
        expect_blanked();
        expect_recovered();
        drive_status(status & ~32'h2);
        expect_blanked();
        expect_recovered();
        @(posedge clk_sys);
        #2;
        downloading = 1'b1;
        expect_blanked();
        repeat (2 * `FRAME_GAME_RST_CYCLES) begin
            @(negedge clk_sys);
            check_bit("game_rst", game_rst, 1'b1);
        end
        @(posedge clk_sys);
        #2;
        downloading = 1'b0;
        expect_recovered();
        if (dut0.sva0.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run("the bound assertion checker reported failures");
        end
    end

endmodule

// File: verilog.f
+incdir+.
frame_ctrl_pkg.sv
frame_input_pkg.sv
frame_dip_decode.sv
frame_joy_map.sv
frame_rst_seq.sv
frame_board.sv
frame_board_sva.sv
tb_frame_board.sv
